//--- bpuTop.f
source/bpuPkg.sv
source/bhtInit.sv
source/branchTargetTable.sv
source/trainingLogic.sv
source/returnStack.sv
source/predictStage.sv
source/bpuTop.sv
sim/bpuTop_assertions.sv
sim/bpuTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the branch predictor testbench with Verilator and runs it.
# Exits nonzero unless the simulation log shows a passing run.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module bpuTb -f bpuTop.f -o bpuSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "no passing result found in $LOG"
exit 1

//--- sim/bpuTb.sv
/*
  Testbench for the fetch-stage branch predictor. Runs the reset sweep,
  directed call, return, jump and branch streams, then LFSR driven
  traffic, and checks every prediction against a reference model.
*/
`timescale 1ns/1ps

module bpuTb;
    import bpuPkg::*;

    localparam int clkPeriod    = 4;
    localparam int randomCycles = 3000;
    localparam int testCycles   = 3200;  // all cycles except the sweep
    localparam int modeReset    = 0;
    localparam int modeIdle     = 1;
    localparam int modeDirect   = 2;
    localparam int modeRandom   = 3;

    logic                  clk;
    logic                  reset;
    logic [31:0]           fetchPc;
    logic                  fetchWr;
    logic                  fetchFlush;
    logic                  decodeIsBranch;
    logic                  updValid;
    logic [31:0]           updPc;
    logic [31:0]           updTarget;
    logic [kindWidth-1:0]  updKind;
    logic                  updTaken;
    logic                  updHit;
    logic [1:0]            updCount;
    logic [indexWidth-1:0] updIndex;
    logic [31:0]           predTarget;
    logic                  predTaken;
    logic [kindWidth-1:0]  predKind;
    logic                  predHit;
    logic [1:0]            predCount;
    logic [indexWidth-1:0] predIndex;
    logic                  predValid;
    logic                  ready;

    // reference model
    logic [tagWidth-1:0]      mTag [tableDepth];
    logic [31:0]              mTarget [tableDepth];
    logic [kindWidth-1:0]     mKind [tableDepth];
    logic [1:0]               mCount [tableDepth];
    logic [indexWidth-1:0]    mHist;
    logic [stackDepth-1:0]    mStkValid;
    logic [31:0]              mStkAddr [stackDepth];
    logic [stackPtrWidth-1:0] mPtr;
    int                       mSweep;
    logic                     mRegValid;
    logic                     mCaptured;
    int                       mRegSel;
    logic [31:0]              mRegPc;
    logic [indexWidth-1:0]    mRegIndex;
    logic                     mRegHit;
    logic [31:0]              mRegTarget;
    logic [kindWidth-1:0]     mRegKind;
    logic [1:0]               mRegCount;
    logic                     mRegStkValid;
    logic [31:0]              mRegStkAddr;

    // stimulus and bookkeeping
    logic [15:0]           lfsr;
    int                    fetchSel;
    logic                  pendValid;  // prediction waiting to be resolved
    int                    pendSel;
    logic                  pendHit;
    logic [1:0]            pendCount;
    logic [indexWidth-1:0] pendIndex;
    int                    checks;
    int                    errors;
    string                 curTest;

    // small pc pool where entry 5 shares its index bits with entry 0
    logic [31:0] poolPc [8] = '{32'h0040_1000, 32'h0040_1104, 32'h0040_2208, 32'h0040_330c,
                                32'h0040_4410, 32'h0041_1000, 32'h0040_5514, 32'h0040_6618};
    logic [kindWidth-1:0] poolKind [8] = '{kindBranch, kindBranch, kindJump, kindCall,
                                           kindReturn, kindBranch, kindCall, kindReturn};

    bpuTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((tableDepth + testCycles) * 2 * clkPeriod);
        $display("timeout: the predictor test did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    // Galois LFSR stepped once for every bit taken
    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [1:0] trainedCount(logic hit, logic taken, logic [1:0] cnt);
        if (!hit) return taken ? cntWeakTaken : cntWeakNot;
        if (taken) return (cnt == cntStrongTaken) ? cnt : cnt + 2'd1;
        return (cnt == cntStrongNot) ? cnt : cnt - 2'd1;
    endfunction

    task automatic checkAddr(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", curTest, name, exp, act);
        end
    endtask

    task automatic checkKind(input string name, input logic [kindWidth-1:0] exp,
                             input logic [kindWidth-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", curTest, name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %b, actual %b", curTest, name, exp, act);
        end
    endtask

    task automatic checkIndex(input string name, input logic [indexWidth-1:0] exp,
                              input logic [indexWidth-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", curTest, name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %b, actual %b", curTest, name, exp, act);
        end
    endtask

    // one rising edge, using the inputs the DUT sampled at it
    task automatic modelEdge();
        logic [indexWidth-1:0]    idx;
        logic [stackPtrWidth-1:0] top;
        logic                     push;
        int                       i;
        idx       = mHist ^ fetchPc[9:2];
        top       = mPtr - stackPtrWidth'(1);
        push      = updValid && updKind == kindCall;
        mCaptured = 1'b0;
        if (reset) begin
            mHist     = '0;
            mPtr      = '0;
            mStkValid = '0;
            mSweep    = 0;
            mRegValid = 1'b0;
            for (i = 0; i < tableDepth; i++) begin
                mTag[i]    = '0;
                mTarget[i] = '0;
                mKind[i]   = kindNone;
                mCount[i]  = cntStrongNot;
            end
        end else begin
            if (fetchFlush) begin
                mRegValid = 1'b0;
            end else if (fetchWr) begin
                mRegValid    = 1'b1;
                mCaptured    = 1'b1;
                mRegSel      = fetchSel;
                mRegPc       = fetchPc;
                mRegIndex    = idx;
                mRegHit      = mTag[idx] == fetchPc[31:10];
                mRegTarget   = mTarget[idx];
                mRegKind     = mKind[idx];
                mRegCount    = mCount[idx];
                mRegStkValid = push || mStkValid[top];  // same-cycle call bypass
                mRegStkAddr  = push ? updPc + 32'd8 : mStkAddr[top];
            end
            if (mSweep < tableDepth) begin
                mSweep++;
            end else if (updValid) begin
                mTag[updIndex]    = updPc[31:10];
                mTarget[updIndex] = updTarget;
                mKind[updIndex]   = updKind;
                mCount[updIndex]  = trainedCount(updHit, updTaken, updCount);
            end
            if (updValid && updKind == kindBranch) mHist = {mHist[6:0], updTaken};
            if (push) begin
                mStkValid[mPtr] = 1'b1;
                mStkAddr[mPtr]  = updPc + 32'd8;
                mPtr            = mPtr + stackPtrWidth'(1);
            end else if (updValid && updKind == kindReturn) begin
                mPtr = top;
            end
        end
    endtask

    task automatic checkOutputs();
        logic [31:0] expTarget;
        logic        expTaken;
        logic        isReady;
        isReady  = mSweep == tableDepth;
        expTaken = mRegHit && (mRegKind == kindJump || mRegKind == kindCall
                               || mRegKind == kindReturn
                               || (mRegKind == kindBranch && mRegCount[1]));
        if (!expTaken) begin
            expTarget = mRegPc + 32'd8;
        end else if (mRegKind == kindReturn) begin
            expTarget = mRegStkValid ? mRegStkAddr : mRegPc + 32'd8;
        end else begin
            expTarget = mRegTarget;
        end
        checkBit("ready", isReady, ready);
        checkBit("predValid", mRegValid && !decodeIsBranch && isReady, predValid);
        if (mRegValid) begin
            checkBit("predHit", mRegHit, predHit);
            checkBit("predTaken", expTaken, predTaken);
            checkAddr("predTarget", expTarget, predTarget);
            checkKind("predKind", mRegHit ? mRegKind : kindNone, predKind);
            checkCount("predCount", mRegCount, predCount);
            checkIndex("predIndex", mRegIndex, predIndex);
        end
        // resolve side echoes what this prediction reported
        if (mCaptured && isReady) begin
            pendValid = 1'b1;
            pendSel   = mRegSel;
            pendHit   = predHit;
            pendCount = predCount;
            pendIndex = predIndex;
        end
    endtask

    task automatic driveInputs(input int mode, input int sel);
        logic [15:0] r;
        int          s;
        logic        useUpd;
        r      = '0;
        s      = sel;
        useUpd = mode == modeDirect;
        reset          <= mode == modeReset;
        fetchWr        <= mode == modeDirect;
        fetchFlush     <= 1'b0;
        decodeIsBranch <= 1'b0;
        if (mode == modeRandom) begin
            r = takeBits(5);
            s = (r[4:3] == 2'd0) ? int'(r[2:0]) : fetchSel;  // pc mostly repeats
            r = takeBits(10);
            fetchWr        <= r[1:0] != 2'd0;
            fetchFlush     <= r[5:2] == 4'd0;
            decodeIsBranch <= r[7:6] == 2'd0;
            useUpd = r[8];
        end
        fetchSel <= s;
        fetchPc  <= poolPc[s];
        if (useUpd && pendValid) begin
            updValid  <= 1'b1;
            updPc     <= poolPc[pendSel];
            updTarget <= poolPc[pendSel] ^ 32'h0000_f000;
            updKind   <= poolKind[pendSel];
            updHit    <= pendHit;
            updCount  <= pendCount;
            updIndex  <= pendIndex;
            // entry 0 always taken, 1 never, 5 random
            if (poolKind[pendSel] != kindBranch) updTaken <= 1'b1;
            else if (pendSel == 5) updTaken <= r[9];
            else updTaken <= pendSel == 0;
            pendValid = 1'b0;
        end else begin
            updValid <= 1'b0;
        end
    endtask

    task automatic stepCycle(input int mode, input int sel);
        @(posedge clk);
        modelEdge();
        driveInputs(mode, sel);
        @(negedge clk);
        checkOutputs();
    endtask

    initial begin
        reset          = 1'b1;
        fetchPc        = poolPc[0];
        fetchSel       = 0;
        fetchWr        = 1'b0;
        fetchFlush     = 1'b0;
        decodeIsBranch = 1'b0;
        updValid       = 1'b0;
        updPc          = '0;
        updTarget      = '0;
        updKind        = kindNone;
        updTaken       = 1'b0;
        updHit         = 1'b0;
        updCount       = cntStrongNot;
        updIndex       = '0;
        lfsr           = 16'd71;
        pendValid      = 1'b0;
        checks         = 0;
        errors         = 0;
        curTest = "reset";
        repeat (4) stepCycle(modeReset, 0);  // fifth reset edge comes with the next step
        curTest = "sweep";
        repeat (tableDepth + 4) stepCycle(modeIdle, 0);
        curTest = "emptyReturn";
        repeat (6) stepCycle(modeDirect, 4);
        curTest = "call";
        repeat (12) stepCycle(modeDirect, 3);
        curTest = "returnAfterCall";
        repeat (8) stepCycle(modeDirect, 4);
        curTest = "jump";
        repeat (12) stepCycle(modeDirect, 2);
        curTest = "branchTaken";
        repeat (24) stepCycle(modeDirect, 0);
        curTest = "branchNotTaken";
        repeat (24) stepCycle(modeDirect, 1);
        curTest = "random";
        repeat (randomCycles) stepCycle(modeRandom, 0);
        $display("predictor test done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/bpuTop_assertions.sv
/*
  Concurrent checks bound into the predictor top level: ready stays
  up once the sweep is done, a flush drops predValid on the next cycle,
  and the prediction outputs hold while fetch is stalled.
*/
`timescale 1ns/1ps

module bpuTopAssertions
    import bpuPkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic                  fetchWr,
    input logic                  fetchFlush,
    input logic                  ready,
    input logic                  predValid,
    input logic [31:0]           predTarget,
    input logic                  predTaken,
    input logic [kindWidth-1:0]  predKind,
    input logic                  predHit,
    input logic [1:0]            predCount,
    input logic [indexWidth-1:0] predIndex
);

    readyStaysHigh: assert property (@(posedge clk) disable iff (reset) ready |=> ready)
        else $error("ready dropped after the table sweep had finished");

    flushClearsValid: assert property (@(posedge clk) disable iff (reset)
        fetchFlush |=> !predValid)
        else $error("predValid was high in the cycle after fetchFlush");

    // decodeIsBranch may still move predValid, so it is left out here
    holdOnStall: assert property (@(posedge clk) disable iff (reset)
        (!fetchWr && !fetchFlush) |=>
            $stable({predTarget, predTaken, predKind, predHit, predCount, predIndex}))
        else $error("prediction outputs changed while fetchWr was low");

endmodule

bind bpuTop bpuTopAssertions asrt0 (.*);

//--- source/bhtInit.sv
/*
  Owns the branch table write port. After reset it sweeps every entry
  to zero with ready held low, then forwards resolved branch updates
  together with the trained counter value.
*/
`timescale 1ns/1ps

module bhtInit
    import bpuPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  updValid,
    input  logic [indexWidth-1:0] updIndex,
    input  logic [31:0]           updPc,
    input  logic [31:0]           updTarget,
    input  logic [kindWidth-1:0]  updKind,
    input  logic [1:0]            trainCount,
    output logic                  wrEn,
    output logic [indexWidth-1:0] wrIndex,
    output logic [tagWidth-1:0]   wrTag,
    output logic [31:0]           wrTarget,
    output logic [kindWidth-1:0]  wrKind,
    output logic [1:0]            wrCount,
    output logic                  ready
);

    logic                  running;   // 0 = sweep, 1 = run
    logic [indexWidth-1:0] sweepIdx;

    // sweep one entry per cycle, leave for run after the last one
    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            sweepIdx <= '0;
        end else if (!running) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == indexWidth'(tableDepth - 1)) begin
                running <= 1'b1;
            end
        end
    end

    // write port mux, updates dropped while sweeping
    assign wrEn     = running ? updValid : 1'b1;
    assign wrIndex  = running ? updIndex : sweepIdx;
    assign wrTag    = running ? updPc[31:indexWidth+2] : '0;
    assign wrTarget = running ? updTarget : '0;
    assign wrKind   = running ? updKind : kindNone;
    assign wrCount  = running ? trainCount : cntStrongNot;

    assign ready = running;

endmodule

//--- source/bpuPkg.sv
/*
  Shared sizes and encodings for the fetch-stage branch predictor.
  Every RTL block and the testbench pull these in by wildcard import.
*/

package bpuPkg;

    // branch table geometry
    localparam int tableDepth = 256;
    localparam int indexWidth = 8;   // pc bits 9..2
    localparam int tagWidth   = 22;  // pc bits 31..10

    // return stack geometry, the pointer wraps on overflow
    localparam int stackDepth    = 8;
    localparam int stackPtrWidth = 3;

    // branch kind codes as stored in the table
    localparam int kindWidth = 3;

    localparam logic [kindWidth-1:0] kindNone   = 3'd0;  // also the swept value
    localparam logic [kindWidth-1:0] kindBranch = 3'd1;  // conditional
    localparam logic [kindWidth-1:0] kindJump   = 3'd2;
    localparam logic [kindWidth-1:0] kindCall   = 3'd3;  // pushes pc+8
    localparam logic [kindWidth-1:0] kindReturn = 3'd4;  // pops

    // 2-bit saturating counter states, bit 1 is the taken guess
    localparam logic [1:0] cntStrongNot   = 2'b00;
    localparam logic [1:0] cntWeakNot     = 2'b01;
    localparam logic [1:0] cntWeakTaken   = 2'b10;
    localparam logic [1:0] cntStrongTaken = 2'b11;

endpackage

//--- source/bpuTop.sv
/*
  Fetch-stage branch predictor top level. Takes the pre-fetch pc and
  one resolved branch per cycle, and presents a prediction one cycle
  after fetchWr captures the pc.
*/
`timescale 1ns/1ps

module bpuTop
    import bpuPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           fetchPc,
    input  logic                  fetchWr,
    input  logic                  fetchFlush,
    input  logic                  decodeIsBranch,
    input  logic                  updValid,
    input  logic [31:0]           updPc,
    input  logic [31:0]           updTarget,
    input  logic [kindWidth-1:0]  updKind,
    input  logic                  updTaken,
    input  logic                  updHit,
    input  logic [1:0]            updCount,
    input  logic [indexWidth-1:0] updIndex,
    output logic [31:0]           predTarget,
    output logic                  predTaken,
    output logic [kindWidth-1:0]  predKind,
    output logic                  predHit,
    output logic [1:0]            predCount,
    output logic [indexWidth-1:0] predIndex,
    output logic                  predValid,
    output logic                  ready
);

    logic [indexWidth-1:0] lookupIndex;
    logic [1:0]            trainCount;
    logic                  wrEn;
    logic [indexWidth-1:0] wrIndex;
    logic [tagWidth-1:0]   wrTag;
    logic [31:0]           wrTarget;
    logic [kindWidth-1:0]  wrKind;
    logic [1:0]            wrCount;
    logic [tagWidth-1:0]   rdTag;
    logic [31:0]           rdTarget;
    logic [kindWidth-1:0]  rdKind;
    logic [1:0]            rdCount;
    logic                  stackTopValid;
    logic [31:0]           stackTopAddr;

    bhtInit init0 (.*);            // sweep and write port owner
    branchTargetTable table0 (.*);
    trainingLogic train0 (.*);     // history, hash, counter step
    returnStack stack0 (.*);
    predictStage predict0 (.*);

endmodule

//--- source/branchTargetTable.sv
/*
  Branch table storage: tag, target, kind and counter per entry.
  Read is combinational at the hashed lookup index, one write per edge.
  Contents are only defined once the reset sweep has run.
*/
`timescale 1ns/1ps

module branchTargetTable
    import bpuPkg::*;
(
    input  logic                  clk,
    input  logic                  wrEn,
    input  logic [indexWidth-1:0] wrIndex,
    input  logic [tagWidth-1:0]   wrTag,
    input  logic [31:0]           wrTarget,
    input  logic [kindWidth-1:0]  wrKind,
    input  logic [1:0]            wrCount,
    input  logic [indexWidth-1:0] lookupIndex,
    output logic [tagWidth-1:0]   rdTag,
    output logic [31:0]           rdTarget,
    output logic [kindWidth-1:0]  rdKind,
    output logic [1:0]            rdCount
);

    logic [tagWidth-1:0]  tagMem    [tableDepth];
    logic [31:0]          targetMem [tableDepth];
    logic [kindWidth-1:0] kindMem   [tableDepth];
    logic [1:0]           countMem  [tableDepth];

    // single write port, all fields written together
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[wrIndex]    <= wrTag;
            targetMem[wrIndex] <= wrTarget;
            kindMem[wrIndex]   <= wrKind;
            countMem[wrIndex]  <= wrCount;
        end
    end

    /* a lookup in the same cycle as a write to the same entry
       still sees the old contents */
    assign rdTag    = tagMem[lookupIndex];
    assign rdTarget = targetMem[lookupIndex];
    assign rdKind   = kindMem[lookupIndex];
    assign rdCount  = countMem[lookupIndex];

endmodule

//--- source/predictStage.sv
/*
  Prediction register. Captures the table read, pc tag, pc+8 and the
  stack top when fetch advances, then resolves hit, target and taken
  from the captured lookup. Holds on stall, clears on flush.
*/
`timescale 1ns/1ps

module predictStage
    import bpuPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetchWr,
    input  logic                  fetchFlush,
    input  logic [31:0]           fetchPc,
    input  logic                  decodeIsBranch,
    input  logic                  ready,
    input  logic [indexWidth-1:0] lookupIndex,
    input  logic [tagWidth-1:0]   rdTag,
    input  logic [31:0]           rdTarget,
    input  logic [kindWidth-1:0]  rdKind,
    input  logic [1:0]            rdCount,
    input  logic                  stackTopValid,
    input  logic [31:0]           stackTopAddr,
    output logic [31:0]           predTarget,
    output logic                  predTaken,
    output logic [kindWidth-1:0]  predKind,
    output logic                  predHit,
    output logic [1:0]            predCount,
    output logic [indexWidth-1:0] predIndex,
    output logic                  predValid
);

    logic                  regValid;
    logic [tagWidth-1:0]   regTag;
    logic [tagWidth-1:0]   regPcTag;
    logic [31:0]           regTarget;
    logic [kindWidth-1:0]  regKind;
    logic [1:0]            regCount;
    logic [indexWidth-1:0] regIndex;
    logic [31:0]           regPcPlus8;
    logic                  regStackValid;
    logic [31:0]           regStackAddr;

    // flush empties the whole stage so outputs stay defined
    always_ff @(posedge clk) begin
        if (reset || fetchFlush) begin
            regValid      <= 1'b0;
            regTag        <= '0;
            regPcTag      <= '0;
            regTarget     <= '0;
            regKind       <= kindNone;
            regCount      <= cntStrongNot;
            regIndex      <= '0;
            regPcPlus8    <= '0;
            regStackValid <= 1'b0;
            regStackAddr  <= '0;
        end else if (fetchWr) begin
            regValid      <= 1'b1;
            regTag        <= rdTag;
            regPcTag      <= fetchPc[31:indexWidth+2];
            regTarget     <= rdTarget;
            regKind       <= rdKind;
            regCount      <= rdCount;
            regIndex      <= lookupIndex;
            regPcPlus8    <= fetchPc + 32'd8;
            regStackValid <= stackTopValid;
            regStackAddr  <= stackTopAddr;
        end
    end

    assign predHit = (regTag == regPcTag);

    always_comb begin
        predTarget = regPcPlus8;  // fall-through unless the kind says otherwise
        predTaken  = 1'b0;
        if (predHit) begin
            case (regKind)
                kindJump, kindCall: begin
                    predTarget = regTarget;
                    predTaken  = 1'b1;
                end
                kindReturn: begin
                    predTarget = regStackValid ? regStackAddr : regPcPlus8;
                    predTaken  = 1'b1;
                end
                kindBranch: begin
                    predTarget = regCount[1] ? regTarget : regPcPlus8;
                    predTaken  = regCount[1];
                end
                default: ;
            endcase
        end
    end

    assign predKind  = predHit ? regKind : kindNone;
    assign predCount = regCount;
    assign predIndex = regIndex;
    assign predValid = regValid && !decodeIsBranch && ready;  // branch in decode masks

endmodule

//--- source/returnStack.sv
/*
  Return-address stack fed by resolved calls and returns.
  Presents the top entry to fetch, with a call resolving this cycle
  bypassed straight to the output.
*/
`timescale 1ns/1ps

module returnStack
    import bpuPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 updValid,
    input  logic [kindWidth-1:0] updKind,
    input  logic [31:0]          updPc,
    output logic                 stackTopValid,
    output logic [31:0]          stackTopAddr
);

    logic [stackDepth-1:0]    entryValid;
    logic [31:0]              entryAddr [stackDepth];
    logic [stackPtrWidth-1:0] topPtr;     // next free slot
    logic [stackPtrWidth-1:0] topMinus1;  // current top
    logic                     pushNow;
    logic                     popNow;
    logic [31:0]              retAddr;

    assign pushNow   = updValid && (updKind == kindCall);
    assign popNow    = updValid && (updKind == kindReturn);
    assign retAddr   = updPc + 32'd8;  // skip the delay slot
    assign topMinus1 = topPtr - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            topPtr     <= '0;
            entryValid <= '0;
        end else if (pushNow) begin
            entryValid[topPtr] <= 1'b1;
            topPtr             <= topPtr + 1'b1;  // wraps on overflow
        end else if (popNow) begin
            topPtr <= topMinus1;
        end
    end

    always_ff @(posedge clk) begin
        if (pushNow) entryAddr[topPtr] <= retAddr;
    end

    // same-cycle call wins over the stored top
    assign stackTopValid = pushNow ? 1'b1 : entryValid[topMinus1];
    assign stackTopAddr  = pushNow ? retAddr : entryAddr[topMinus1];

endmodule

//--- source/trainingLogic.sv
/*
  Global history and counter training. Forms the lookup index as
  history XOR fetch pc bits and computes the counter value written
  back for a resolved branch.
*/
`timescale 1ns/1ps

module trainingLogic
    import bpuPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           fetchPc,
    input  logic                  updValid,
    input  logic [kindWidth-1:0]  updKind,
    input  logic                  updTaken,
    input  logic                  updHit,
    input  logic [1:0]            updCount,
    output logic [indexWidth-1:0] lookupIndex,
    output logic [1:0]            trainCount
);

    logic [indexWidth-1:0] history;

    // only conditional branches shift the history
    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (updValid && updKind == kindBranch) begin
            history <= {history[indexWidth-2:0], updTaken};
        end
    end

    assign lookupIndex = history ^ fetchPc[indexWidth+1:2];

    // saturating step on a hit, fresh weak state on a miss
    always_comb begin
        if (updHit) begin
            if (updTaken) begin
                if (updCount == cntStrongTaken) trainCount = cntStrongTaken;
                else                            trainCount = updCount + 2'd1;
            end else begin
                if (updCount == cntStrongNot) trainCount = cntStrongNot;
                else                          trainCount = updCount - 2'd1;
            end
        end else begin
            trainCount = updTaken ? cntWeakTaken : cntWeakNot;
        end
    end

endmodule
